// File: Makefile
# Verilator simulation of the x86 pre-decode stage

TOP := tb_x86_predecode

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check sim.log for the pass message"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

obj_dir/V$(TOP): verilog.f $(wildcard verilog/*.sv) sim/tb_x86_predecode.sv
	verilator --binary --timing -f verilog.f --top-module $(TOP) -o V$(TOP)

test: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -qF "** PASS **" sim.log; then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: sim/predecode_vectors.txt
# window (byte 0 in the low lane), then expected: rep seg seg_flag opsize pfx_enc pfx_onehot
# opcode known imm_bytes imm_value length; every column is hex
7766554433221190 0 00 0 0 0 1 90 1 0 00000000 1
01FFEEDDCCBBAAC3 0 00 0 0 0 1 C3 1 0 00000000 1
DEBC9A7856341253 0 00 0 0 0 1 53 1 0 00000000 1
0605040302017FB1 0 00 0 0 0 1 B1 1 1 0000007F 2
000000000000806A 0 00 0 0 0 1 6A 1 1 00000080 2
999999999999FEEB 0 00 0 0 0 1 EB 1 1 000000FE 2
55555555551234C2 0 00 0 0 0 1 C2 1 2 00001234 3
ABABAB12345678B8 0 00 0 0 0 1 B8 1 4 12345678 5
000000DEADBEEF68 0 00 0 0 0 1 68 1 4 DEADBEEF 5
11111180000001E9 0 00 0 0 0 1 E9 1 4 80000001 5
FFFFFFEFABCDBF66 0 00 0 1 1 2 BF 1 2 0000ABCD 4
2222222210006866 0 00 0 1 1 2 68 1 2 00001000 4
33333333FFFEE966 0 00 0 1 1 2 E9 1 2 0000FFFE 4
444444444442B066 0 00 0 1 1 2 B0 1 1 00000042 3
555555550010C266 0 00 0 1 1 2 C2 1 2 00000010 4
0000000000009066 0 00 0 1 1 2 90 1 0 00000000 2
000000000000902E 0 01 1 0 1 2 90 1 0 00000000 2
0000000000009036 0 02 1 0 1 2 90 1 0 00000000 2
000000000000903E 0 04 1 0 1 2 90 1 0 00000000 2
0000000000009026 0 08 1 0 1 2 90 1 0 00000000 2
0000000000009064 0 10 1 0 1 2 90 1 0 00000000 2
0000000000009065 0 20 1 0 1 2 90 1 0 00000000 2
000000000000C3F3 1 00 0 0 1 2 C3 1 0 00000000 2
7777771234B866F3 1 00 0 1 2 4 B8 1 2 00001234 5
000000056AF3662E 1 01 1 1 3 8 6A 1 1 00000005 5
0011223344686564 0 30 1 0 2 4 68 1 4 11223344 7
12345678B9363E26 0 0E 1 0 3 8 B9 1 4 12345678 8
0000ABCDBA666666 0 00 0 1 3 8 BA 1 2 0000ABCD 6
000000000090F3F3 1 00 0 0 2 4 90 1 0 00000000 3
111111B866666666 0 00 0 1 3 8 66 0 0 00000000 4
00000000002E6690 0 00 0 0 0 1 90 1 0 00000000 1
0000000000F3902E 0 01 1 0 1 2 90 1 0 00000000 2
000000000066B866 0 00 0 1 1 2 B8 1 2 00000066 4
000000000000050F 0 00 0 0 0 1 0F 0 0 00000000 1
000000000000A4F2 0 00 0 0 0 1 F2 0 0 00000000 1
000000000000CC64 0 10 1 0 1 2 CC 0 0 00000000 2
000000000000C766 0 00 0 1 1 2 C7 0 0 00000000 2
FFFFFFFFFFFFFF57 0 00 0 0 0 1 57 1 0 00000000 1
EEEEEEEEEEEEFFB7 0 00 0 0 0 1 B7 1 1 000000FF 2
0000000000000058 0 00 0 0 0 1 58 0 0 00000000 1

// File: sim/tb_x86_predecode.sv
`timescale 1ns/1ps

module tb_x86_predecode;
    import decode_pkg::*;

    logic                   clk;
    logic                   rst;
    logic                   in_valid;
    logic                   in_ready;
    window_t                in_window;
    logic                   out_valid;
    logic                   out_ready;
    logic                   is_rep;
    logic [SEG_COUNT-1:0]   seg_override;
    logic                   is_seg_override;
    logic                   is_opsize_override;
    logic [PFX_CNT_W-1:0]   num_prefixes_encoded;
    logic [PFX_OH_W-1:0]    num_prefixes_onehot;
    logic [7:0]             opcode;
    logic                   op_known;
    logic [IMM_BYTES_W-1:0] imm_bytes;
    logic [IMM_W-1:0]       imm_value;
    logic [LEN_W-1:0]       insn_length;

    window_t  vec_win[$];   // windows from the vector file
    decoded_t vec_exp[$];   // matching expected results
    decoded_t exp_q[$];     // scoreboard, accepted but not yet seen

    int seed = 32'h9417;
    int errors = 0;
    int transfers = 0;
    int cycle = 0;
    int limit = 0;
    int stream_start = 0;
    int stream_count = 0;
    bit stream_phase = 1'b0;

    x86_predecode_top UUT (
        .clk                  (clk),
        .rst                  (rst),
        .in_valid             (in_valid),
        .in_ready             (in_ready),
        .in_window            (in_window),
        .out_valid            (out_valid),
        .out_ready            (out_ready),
        .is_rep               (is_rep),
        .seg_override         (seg_override),
        .is_seg_override      (is_seg_override),
        .is_opsize_override   (is_opsize_override),
        .num_prefixes_encoded (num_prefixes_encoded),
        .num_prefixes_onehot  (num_prefixes_onehot),
        .opcode               (opcode),
        .op_known             (op_known),
        .imm_bytes            (imm_bytes),
        .imm_value            (imm_value),
        .insn_length          (insn_length)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [63:0] seen,
                               input logic [63:0] expected);
        if (seen !== expected) begin
            errors++;
            $display("Mismatch at %0t: %s seen %0h expected %0h", $time, name, seen, expected);
        end
    endtask

    task automatic compare_result(input decoded_t want);
        check_value("is_rep", 64'(is_rep), 64'(want.is_rep));
        check_value("seg_override", 64'(seg_override), 64'(want.seg_override));
        check_value("is_seg_override", 64'(is_seg_override), 64'(want.is_seg_override));
        check_value("is_opsize_override", 64'(is_opsize_override),
                    64'(want.is_opsize_override));
        check_value("num_prefixes_encoded", 64'(num_prefixes_encoded),
                    64'(want.num_prefixes_encoded));
        check_value("num_prefixes_onehot", 64'(num_prefixes_onehot),
                    64'(want.num_prefixes_onehot));
        check_value("opcode", 64'(opcode), 64'(want.opcode));
        check_value("op_known", 64'(op_known), 64'(want.op_known));
        check_value("imm_bytes", 64'(imm_bytes), 64'(want.imm_bytes));
        check_value("imm_value", 64'(imm_value), 64'(want.imm_value));
        check_value("insn_length", 64'(insn_length), 64'(want.insn_length));
    endtask

    // one window plus eleven expected fields per line, all hex
    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        window_t     w;
        logic [31:0] f_rep, f_seg, f_segf, f_ops, f_enc, f_oh;
        logic [31:0] f_opc, f_known, f_immb, f_immv, f_len;
        decoded_t    d;
        fd = $fopen("sim/predecode_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open the vector file sim/predecode_vectors.txt");
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() >= 2 && line[0] != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h", w, f_rep,
                                f_seg, f_segf, f_ops, f_enc, f_oh, f_opc, f_known,
                                f_immb, f_immv, f_len);
                    if (n != 12) begin
                        $display("vector line could not be read: %s", line);
                        errors++;
                    end else begin
                        d.is_rep               = f_rep[0];
                        d.seg_override         = f_seg[SEG_COUNT-1:0];
                        d.is_seg_override      = f_segf[0];
                        d.is_opsize_override   = f_ops[0];
                        d.num_prefixes_encoded = f_enc[PFX_CNT_W-1:0];
                        d.num_prefixes_onehot  = f_oh[PFX_OH_W-1:0];
                        d.opcode               = f_opc[7:0];
                        d.op_known             = f_known[0];
                        d.imm_bytes            = f_immb[IMM_BYTES_W-1:0];
                        d.imm_value            = f_immv;
                        d.insn_length          = f_len[LEN_W-1:0];
                        vec_win.push_back(w);
                        vec_exp.push_back(d);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // called just after a rising edge; valid holds until the window is taken
    task automatic drive_vectors(input bit random_gaps);
        int idx;
        bit accepted;
        idx = 0;
        while (idx < vec_win.size()) begin
            if (!in_valid) begin
                if (!random_gaps || ($random(seed) & 3) != 0) begin
                    in_valid  = 1'b1;
                    in_window = vec_win[idx];
                end
            end
            @(negedge clk);
            accepted = in_valid && in_ready;
            if (accepted) begin
                if (stream_phase && idx == 0) begin
                    stream_start = cycle;
                end
                exp_q.push_back(vec_exp[idx]);
                idx++;
            end
            @(posedge clk);
            #1;
            if (accepted) begin
                in_valid = 1'b0;
            end
        end
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    // back-pressure about a quarter of the time, none while streaming
    always @(posedge clk) begin
        #1;
        if (rst || stream_phase) begin
            out_ready = 1'b1;
        end else begin
            out_ready = (($random(seed) & 3) != 0);
        end
    end

    // handshakes are stable at the falling edge
    always @(negedge clk) begin
        if (!rst && out_valid && out_ready) begin
            transfers++;
            if (exp_q.size() == 0) begin
                $display("result delivered at %0t with no window outstanding", $time);
                errors++;
            end else begin
                compare_result(exp_q.pop_front());
            end
            if (stream_phase) begin
                check_value("stream latency", 64'(cycle - stream_start), 64'(2 + stream_count));
                stream_count++;
            end
        end
    end

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (limit > 0 && cycle >= limit) begin
            $display("timeout after %0d cycles, results still outstanding: %0d",
                     cycle, exp_q.size());
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_window = '0;
        out_ready = 1'b1;
        load_vectors();
        if (vec_win.size() == 0) begin
            $display("no test vectors were loaded");
            errors++;
        end else begin
            limit = vec_win.size() * 8 + 100;
            repeat (16) @(posedge clk);
            #1;
            rst = 1'b0;
            @(negedge clk);
            check_value("out_valid", 64'(out_valid), 64'd0);  // idle after reset
            check_value("in_ready", 64'(in_ready), 64'd1);
            @(posedge clk);
            #1;
            drive_vectors(1'b1);     // gaps and back-pressure
            drain();
            stream_phase = 1'b1;
            out_ready    = 1'b1;
            drive_vectors(1'b0);     // back to back
            drain();
            check_value("transfers", 64'(transfers), 64'(2 * vec_win.size()));
        end
        $display("errors: %0d, transfers: %0d", errors, transfers);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: verilog.f
verilog/decode_pkg.sv
verilog/prefix_cmp.sv
verilog/prefix_decode.sv
verilog/opcode_length.sv
verilog/pipe_reg.sv
verilog/x86_predecode_top.sv
sim/tb_x86_predecode.sv

// File: verilog/decode_pkg.sv
package decode_pkg;

    // window and field sizes
    localparam int WINDOW_BYTES = 8;
    localparam int MAX_PREFIXES = 3;
    localparam int SEG_COUNT    = 6;
    localparam int PFX_CNT_W    = 2;                // encoded prefix count
    localparam int PFX_OH_W     = MAX_PREFIXES + 1; // one-hot prefix count
    localparam int IMM_BYTES_W  = 3;
    localparam int IMM_W        = 32;
    localparam int LEN_W        = 4;

    // legacy prefix byte codes
    localparam logic [7:0] PFX_REP    = 8'hF3;
    localparam logic [7:0] PFX_CS     = 8'h2E;
    localparam logic [7:0] PFX_SS     = 8'h36;
    localparam logic [7:0] PFX_DS     = 8'h3E;
    localparam logic [7:0] PFX_ES     = 8'h26;
    localparam logic [7:0] PFX_FS     = 8'h64;
    localparam logic [7:0] PFX_GS     = 8'h65;
    localparam logic [7:0] PFX_OPSIZE = 8'h66;

    // bit positions in the one-hot segment override
    localparam int SEG_CS = 0;
    localparam int SEG_SS = 1;
    localparam int SEG_DS = 2;
    localparam int SEG_ES = 3;
    localparam int SEG_FS = 4;
    localparam int SEG_GS = 5;

    // byte 0 sits in bits 7:0
    typedef logic [WINDOW_BYTES*8-1:0] window_t;

    // opcode classes, by immediate size
    typedef enum logic [2:0] {
        CLS_UNKNOWN,
        CLS_IMM0,
        CLS_IMM8,
        CLS_IMM16,
        CLS_IMMZ    // 4 bytes, 2 under operand size override
    } op_class_t;

    typedef struct packed {
        logic                   is_rep;
        logic [SEG_COUNT-1:0]   seg_override;
        logic                   is_seg_override;
        logic                   is_opsize_override;
        logic [PFX_CNT_W-1:0]   num_prefixes_encoded;
        logic [PFX_OH_W-1:0]    num_prefixes_onehot;
        logic [7:0]             opcode;
        logic                   op_known;
        logic [IMM_BYTES_W-1:0] imm_bytes;
        logic [IMM_W-1:0]       imm_value;
        logic [LEN_W-1:0]       insn_length;
    } decoded_t;

endpackage

// File: verilog/opcode_length.sv
`timescale 1ns/1ps

module opcode_length (
    input  decode_pkg::window_t                window,
    input  logic [decode_pkg::PFX_CNT_W-1:0]   num_prefixes_encoded,
    input  logic                               is_opsize_override,
    output logic [7:0]                         opcode,
    output logic                               op_known,
    output logic [decode_pkg::IMM_BYTES_W-1:0] imm_bytes,
    output logic [decode_pkg::IMM_W-1:0]       imm_value,
    output logic [decode_pkg::LEN_W-1:0]       insn_length
);
    import decode_pkg::*;

    op_class_t                 op_class;
    logic [2:0]                imm_pos;     // byte index of first immediate byte
    window_t                   tail;
    logic [IMM_W-1:0]          imm_mask;

    // opcode follows the prefixes
    assign opcode  = window[{num_prefixes_encoded, 3'b000} +: 8];
    assign imm_pos = {1'b0, num_prefixes_encoded} + 3'd1;

    // fixed one-byte subset
    always_comb begin
        casez (opcode)
            8'h90, 8'hC3:  op_class = CLS_IMM0;   // nop, ret
            8'b0101_0???:  op_class = CLS_IMM0;   // push reg
            8'b1011_0???:  op_class = CLS_IMM8;   // mov r8, imm8
            8'h6A, 8'hEB:  op_class = CLS_IMM8;   // push imm8, jmp rel8
            8'hC2:         op_class = CLS_IMM16;  // ret imm16
            8'b1011_1???:  op_class = CLS_IMMZ;   // mov r, imm
            8'h68, 8'hE9:  op_class = CLS_IMMZ;   // push imm, jmp rel
            default:       op_class = CLS_UNKNOWN;
        endcase
    end

    assign op_known = (op_class != CLS_UNKNOWN);

    always_comb begin
        case (op_class)
            CLS_IMM8:  imm_bytes = 3'd1;
            CLS_IMM16: imm_bytes = 3'd2;
            CLS_IMMZ:  imm_bytes = is_opsize_override ? 3'd2 : 3'd4;
            default:   imm_bytes = 3'd0;  // no immediate or unknown
        endcase
    end

    // line up the immediate at bit 0
    assign tail = window >> {imm_pos, 3'b000};

    always_comb begin
        case (imm_bytes)
            3'd1:    imm_mask = 32'h0000_00FF;
            3'd2:    imm_mask = 32'h0000_FFFF;
            3'd4:    imm_mask = 32'hFFFF_FFFF;
            default: imm_mask = '0;
        endcase
    end

    // little-endian, zero-extended
    assign imm_value = tail[IMM_W-1:0] & imm_mask;

    // at most 3 + 1 + 4 = 8 bytes
    assign insn_length = LEN_W'(num_prefixes_encoded) + LEN_W'(1) + LEN_W'(imm_bytes);

endmodule

// File: verilog/pipe_reg.sv
`timescale 1ns/1ps

// one-entry valid/ready register stage
module pipe_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    output logic in_ready,
    input  T     in_data,
    output logic out_valid,
    input  logic out_ready,
    output T     out_data
);

    // empty, or content leaving this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    // payload only moves on a transfer
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

endmodule

// File: verilog/prefix_cmp.sv
`timescale 1ns/1ps

// one byte against every known prefix code
module prefix_cmp (
    input  logic [7:0]                       prefix,
    output logic                             is_rep,
    output logic [decode_pkg::SEG_COUNT-1:0] seg_override,  // one-hot
    output logic                             is_opsize_override
);
    import decode_pkg::*;

    assign is_rep = (prefix == PFX_REP);

    // segment overrides, one bit each
    assign seg_override[SEG_CS] = (prefix == PFX_CS);
    assign seg_override[SEG_SS] = (prefix == PFX_SS);
    assign seg_override[SEG_DS] = (prefix == PFX_DS);
    assign seg_override[SEG_ES] = (prefix == PFX_ES);
    assign seg_override[SEG_FS] = (prefix == PFX_FS);
    assign seg_override[SEG_GS] = (prefix == PFX_GS);

    assign is_opsize_override = (prefix == PFX_OPSIZE);

endmodule

// File: verilog/prefix_decode.sv
`timescale 1ns/1ps

module prefix_decode (
    input  decode_pkg::window_t                window,
    output logic                               is_rep,
    output logic [decode_pkg::SEG_COUNT-1:0]   seg_override,
    output logic                               is_seg_override,
    output logic                               is_opsize_override,
    output logic [decode_pkg::PFX_CNT_W-1:0]   num_prefixes_encoded,
    output logic [decode_pkg::PFX_OH_W-1:0]    num_prefixes_onehot
);
    import decode_pkg::*;

    // per-byte compare results
    logic [MAX_PREFIXES-1:0] rep_hit;
    logic [MAX_PREFIXES-1:0] opsize_hit;
    logic [MAX_PREFIXES-1:0] any_hit;
    logic [MAX_PREFIXES-1:0] counted;   // thermometer of leading prefixes
    logic [SEG_COUNT-1:0]    seg_hit [MAX_PREFIXES];

    for (genvar i = 0; i < MAX_PREFIXES; i++) begin : g_cmp
        prefix_cmp u_cmp (
            .prefix             (window[8*i +: 8]),
            .is_rep             (rep_hit[i]),
            .seg_override       (seg_hit[i]),
            .is_opsize_override (opsize_hit[i])
        );

        assign any_hit[i] = rep_hit[i] | opsize_hit[i] | (|seg_hit[i]);
    end

    // a prefix only counts while every byte before it was one too
    always_comb begin
        counted[0] = any_hit[0];
        for (int i = 1; i < MAX_PREFIXES; i++) begin
            counted[i] = counted[i-1] & any_hit[i];
        end
    end

    always_comb begin
        is_rep             = 1'b0;
        seg_override       = '0;
        is_opsize_override = 1'b0;
        for (int i = 0; i < MAX_PREFIXES; i++) begin
            if (counted[i]) begin
                is_rep             = is_rep | rep_hit[i];
                seg_override       = seg_override | seg_hit[i]; // two segs set two bits
                is_opsize_override = is_opsize_override | opsize_hit[i];
            end
        end
    end

    assign is_seg_override = |seg_override;

    // thermometer to binary count
    always_comb begin
        if (counted[2]) begin
            num_prefixes_encoded = 2'd3;
        end else if (counted[1]) begin
            num_prefixes_encoded = 2'd2;
        end else if (counted[0]) begin
            num_prefixes_encoded = 2'd1;
        end else begin
            num_prefixes_encoded = 2'd0;
        end
    end

    // bit k set for k prefixes
    assign num_prefixes_onehot = PFX_OH_W'(1) << num_prefixes_encoded;

endmodule

// File: verilog/x86_predecode_top.sv
`timescale 1ns/1ps

module x86_predecode_top (
    input  logic                               clk,
    input  logic                               rst,

    // window stream in
    input  logic                               in_valid,
    output logic                               in_ready,
    input  decode_pkg::window_t                in_window,

    // decoded stream out
    output logic                               out_valid,
    input  logic                               out_ready,
    output logic                               is_rep,
    output logic [decode_pkg::SEG_COUNT-1:0]   seg_override,
    output logic                               is_seg_override,
    output logic                               is_opsize_override,
    output logic [decode_pkg::PFX_CNT_W-1:0]   num_prefixes_encoded,
    output logic [decode_pkg::PFX_OH_W-1:0]    num_prefixes_onehot,
    output logic [7:0]                         opcode,
    output logic                               op_known,
    output logic [decode_pkg::IMM_BYTES_W-1:0] imm_bytes,
    output logic [decode_pkg::IMM_W-1:0]       imm_value,
    output logic [decode_pkg::LEN_W-1:0]       insn_length
);
    import decode_pkg::*;

    // stage 1, registered window
    logic     win_valid;
    logic     win_ready;
    window_t  win_data;

    // combinational decode of the registered window
    logic                   dec_is_rep;
    logic [SEG_COUNT-1:0]   dec_seg_override;
    logic                   dec_is_seg_override;
    logic                   dec_is_opsize_override;
    logic [PFX_CNT_W-1:0]   dec_num_prefixes_encoded;
    logic [PFX_OH_W-1:0]    dec_num_prefixes_onehot;
    logic [7:0]             dec_opcode;
    logic                   dec_op_known;
    logic [IMM_BYTES_W-1:0] dec_imm_bytes;
    logic [IMM_W-1:0]       dec_imm_value;
    logic [LEN_W-1:0]       dec_insn_length;

    // stage 2, registered result
    decoded_t res_in;
    decoded_t res_out;

    pipe_reg #(.T(window_t)) u_win_reg (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_window),
        .out_valid (win_valid),
        .out_ready (win_ready),
        .out_data  (win_data)
    );

    prefix_decode u_prefix_decode (
        .window               (win_data),
        .is_rep               (dec_is_rep),
        .seg_override         (dec_seg_override),
        .is_seg_override      (dec_is_seg_override),
        .is_opsize_override   (dec_is_opsize_override),
        .num_prefixes_encoded (dec_num_prefixes_encoded),
        .num_prefixes_onehot  (dec_num_prefixes_onehot)
    );

    opcode_length u_opcode_length (
        .window               (win_data),
        .num_prefixes_encoded (dec_num_prefixes_encoded),
        .is_opsize_override   (dec_is_opsize_override),
        .opcode               (dec_opcode),
        .op_known             (dec_op_known),
        .imm_bytes            (dec_imm_bytes),
        .imm_value            (dec_imm_value),
        .insn_length          (dec_insn_length)
    );

    always_comb begin
        res_in.is_rep               = dec_is_rep;
        res_in.seg_override         = dec_seg_override;
        res_in.is_seg_override      = dec_is_seg_override;
        res_in.is_opsize_override   = dec_is_opsize_override;
        res_in.num_prefixes_encoded = dec_num_prefixes_encoded;
        res_in.num_prefixes_onehot  = dec_num_prefixes_onehot;
        res_in.opcode               = dec_opcode;
        res_in.op_known             = dec_op_known;
        res_in.imm_bytes            = dec_imm_bytes;
        res_in.imm_value            = dec_imm_value;
        res_in.insn_length          = dec_insn_length;
    end

    pipe_reg #(.T(decoded_t)) u_res_reg (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (win_valid),
        .in_ready  (win_ready),   // stalls the window stage
        .in_data   (res_in),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (res_out)
    );

    // unpack onto loose ports
    assign is_rep               = res_out.is_rep;
    assign seg_override         = res_out.seg_override;
    assign is_seg_override      = res_out.is_seg_override;
    assign is_opsize_override   = res_out.is_opsize_override;
    assign num_prefixes_encoded = res_out.num_prefixes_encoded;
    assign num_prefixes_onehot  = res_out.num_prefixes_onehot;
    assign opcode               = res_out.opcode;
    assign op_known             = res_out.op_known;
    assign imm_bytes            = res_out.imm_bytes;
    assign imm_value            = res_out.imm_value;
    assign insn_length          = res_out.insn_length;

endmodule
